// File: Bender.yml
package:
  name: mesh_router

sources:
  - design/noc_pkg.sv
  - design/rr_arbiter.sv
  - design/vc_input_buffer.sv
  - design/output_unit.sv
  - design/switch_ctrl.sv
  - design/mesh_router.sv
  - target: test
    files:
      - bench/router_tb.sv

// File: all.f
design/noc_pkg.sv
design/rr_arbiter.sv
design/vc_input_buffer.sv
design/output_unit.sv
design/switch_ctrl.sv
design/mesh_router.sv
bench/router_tb.sv

// File: bench/router_tb.sv
`default_nettype none

module router_tb;

    import noc_pkg::*;

    localparam int     BUF_DEPTH = 4;
    localparam int     QD        = 512;
    localparam int     QUIET     = 10;
    localparam coord_t MY_X      = 2'd1;
    localparam coord_t MY_Y      = 2'd2;

    logic               clk = 1'b0;
    logic               rst;
    flit_t              idata [N_PORTS];
    logic [N_PORTS-1:0] ivalid;
    vc_id_t             ivch  [N_PORTS];
    logic [N_VC-1:0]    oack  [N_PORTS];
    flit_t              odata [N_PORTS];
    logic [N_PORTS-1:0] ovalid;
    vc_id_t             ovch  [N_PORTS];
    logic [N_VC-1:0]    iack  [N_PORTS];

    flit_t      exp_flit [N_PORTS*N_VC][QD];   // expected flits per source port and vc.
    port_id_t   exp_port [N_PORTS*N_VC][QD];
    int         q_wr [N_PORTS*N_VC];
    int         q_rd [N_PORTS*N_VC];
    port_id_t   cur_route [N_PORTS][N_VC];
    int         owner [N_PORTS][N_VC];       // source holding each output vc or -1 when free.
    int         up_credit [N_PORTS][N_VC];
    int         pend [N_PORTS][N_VC];        // received flits not yet acknowledged.
    int         sent [N_PORTS][N_VC];
    int         acked [N_PORTS][N_VC];
    int         pkt_len [N_PORTS];
    int         pkt_pos [N_PORTS];
    int         pkt_vc [N_PORTS];
    coord_t     pkt_dx [N_PORTS];
    coord_t     pkt_dy [N_PORTS];
    int         to_gen [N_PORTS];
    int         cyc;
    int         seq;
    int         rx_count;
    int         last_cyc;
    int         blocked_out;
    logic       ack_random;
    port_id_t   last_port;
    flit_t      last_flit;
    vc_id_t     last_vc;
    string      test_name;
    coord_t     dir_x [N_PORTS] = '{2'd1, 2'd1, 2'd3, 2'd1, 2'd0};
    coord_t     dir_y [N_PORTS] = '{2'd2, 2'd3, 2'd0, 2'd0, 2'd1};
    port_id_t   dir_p [N_PORTS] = '{PORT_LOCAL, PORT_NORTH, PORT_EAST, PORT_SOUTH, PORT_WEST};

    mesh_router #(
        .BUF_DEPTH(BUF_DEPTH)
    ) dut_i (
        .clk   (clk),
        .rst   (rst),
        .my_x  (MY_X),
        .my_y  (MY_Y),
        .idata (idata),
        .ivalid(ivalid),
        .ivch  (ivch),
        .oack  (oack),
        .odata (odata),
        .ovalid(ovalid),
        .ovch  (ovch),
        .iack  (iack)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "router testbench stopped at the first error");
    endtask

    task automatic fail_run(string msg);
        $display("Error in test %s: %s", test_name, msg);
        stop_run();
    endtask

    task automatic check_flit(string what, flit_t exp, flit_t act);
        if (act !== exp) begin
            $display("Mismatch in test %s, %s: expected %h, actual %h",
                     test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_port(string what, port_id_t exp, port_id_t act);
        if (act !== exp) begin
            $display("Mismatch in test %s, %s: expected %0d, actual %0d",
                     test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            $display("Mismatch in test %s, %s: expected %0d, actual %0d",
                     test_name, what, exp, act);
            stop_run();
        end
    endtask

    // x is resolved first, then y, as seen from this router.
    function automatic port_id_t xy_expect(coord_t dx, coord_t dy);
        if (dx > MY_X)
            return PORT_EAST;
        if (dx < MY_X)
            return PORT_WEST;
        if (dy > MY_Y)
            return PORT_NORTH;
        if (dy < MY_Y)
            return PORT_SOUTH;
        return PORT_LOCAL;
    endfunction

    function automatic flit_t make_flit(flit_kind_t k, coord_t dx, coord_t dy, port_id_t src,
                                        int n);
        return {k, dx, dy, src, 26'(n)};   // payload is source port over sequence number.
    endfunction

    task automatic send_flit(int p, int v, flit_t f);
        int idx;
        idx = p * N_VC + v;
        if (f[34:33] == KIND_HEAD || f[34:33] == KIND_SINGLE)
            cur_route[p][v] = xy_expect(f[32:31], f[30:29]);
        exp_flit[idx][q_wr[idx] % QD] = f;
        exp_port[idx][q_wr[idx] % QD] = cur_route[p][v];
        q_wr[idx]++;
        up_credit[p][v]--;
        sent[p][v]++;
        idata[p]  = f;
        ivalid[p] = 1'b1;
        ivch[p]   = vc_id_t'(v);
    endtask

    task automatic receive(int o, int v, flit_t f);
        int         src;
        int         idx;
        flit_kind_t k;
        k   = f[34:33];
        src = int'(f[28:26]);
        if (src >= N_PORTS)
            fail_run($sformatf("output %0d carried a flit with a bad source field", o));
        if (owner[o][v] < 0) begin
            if (k != KIND_HEAD && k != KIND_SINGLE)
                fail_run($sformatf("output %0d vc %0d sent a body flit with no head", o, v));
            owner[o][v] = src;
        end
        check_port("packet source", port_id_t'(owner[o][v]), port_id_t'(src));
        idx = src * N_VC + v;
        if (q_rd[idx] == q_wr[idx])
            fail_run($sformatf("output %0d delivered a flit that was never sent", o));
        check_flit("flit order", exp_flit[idx][q_rd[idx] % QD], f);
        check_port("output port", exp_port[idx][q_rd[idx] % QD], port_id_t'(o));
        q_rd[idx]++;
        if (k == KIND_TAIL || k == KIND_SINGLE)
            owner[o][v] = -1;
        pend[o][v]++;
        if (pend[o][v] > BUF_DEPTH)
            fail_run($sformatf("output %0d vc %0d sent more flits than its credits", o, v));
        last_port = port_id_t'(o);
        last_flit = f;
        last_vc   = vc_id_t'(v);
        last_cyc  = cyc;
        rx_count++;
    endtask

    // one clock that observes the outputs and then drives the acks for the new cycle.
    task automatic tick();
        @(posedge clk);
        #1;
        cyc++;
        for (int p = 0; p < N_PORTS; p++) begin
            for (int v = 0; v < N_VC; v++) begin
                if (oack[p][v]) begin
                    up_credit[p][v]++;
                    acked[p][v]++;
                end
            end
        end
        for (int o = 0; o < N_PORTS; o++) begin
            if (ovalid[o])
                receive(o, int'(ovch[o]), odata[o]);
        end
        ivalid = '0;
        for (int o = 0; o < N_PORTS; o++) begin
            for (int v = 0; v < N_VC; v++) begin
                iack[o][v] = 1'b0;
                if (pend[o][v] > 0 && o != blocked_out && (!ack_random || $urandom % 3 != 0)) begin
                    iack[o][v] = 1'b1;
                    pend[o][v]--;
                end
            end
        end
    endtask

    task automatic gen_traffic();
        flit_kind_t k;
        for (int p = 0; p < N_PORTS; p++) begin
            if (pkt_pos[p] == pkt_len[p] && to_gen[p] > 0 && $urandom % 2 == 0) begin
                pkt_len[p] = 1 + $urandom % 4;
                pkt_pos[p] = 0;
                pkt_vc[p]  = $urandom % N_VC;
                pkt_dx[p]  = coord_t'($urandom);
                pkt_dy[p]  = coord_t'($urandom);
                to_gen[p]--;
            end
            if (pkt_pos[p] < pkt_len[p] && up_credit[p][pkt_vc[p]] > 0 && $urandom % 4 != 0) begin
                if (pkt_len[p] == 1)
                    k = KIND_SINGLE;
                else if (pkt_pos[p] == 0)
                    k = KIND_HEAD;
                else if (pkt_pos[p] == pkt_len[p] - 1)
                    k = KIND_TAIL;
                else
                    k = KIND_BODY;
                send_flit(p, pkt_vc[p], make_flit(k, pkt_dx[p], pkt_dy[p], port_id_t'(p), seq));
                seq++;
                pkt_pos[p]++;
            end
        end
    endtask

    function automatic logic drained();
        for (int p = 0; p < N_PORTS; p++) begin
            if (to_gen[p] > 0 || pkt_pos[p] != pkt_len[p])
                return 1'b0;
            for (int v = 0; v < N_VC; v++) begin
                if (pend[p][v] > 0)
                    return 1'b0;
            end
        end
        return (cyc - last_cyc) >= QUIET;   // no flit has left the router for a while.
    endfunction

    task automatic run_traffic(int pkts, int blk, int blk_cycles, int limit);
        int n;
        n = 0;
        for (int p = 0; p < N_PORTS; p++)
            to_gen[p] = pkts;
        blocked_out = blk;
        while (n < blk_cycles || !drained()) begin
            if (n == blk_cycles)
                blocked_out = -1;   // the held acks now flow back.
            tick();
            gen_traffic();
            n++;
            if (n > limit)
                fail_run("random traffic did not drain before the timeout");
        end
    endtask

    initial begin
        flit_t f;
        int    seed_val;
        int    n0;
        int    t0;
        int    n;
        seed_val = $urandom(32'h9a37_4b2c);
        rst    = 1'b1;
        ivalid = '0;
        for (int p = 0; p < N_PORTS; p++) begin
            idata[p]   = '0;
            ivch[p]    = '0;
            iack[p]    = '0;
            pkt_len[p] = 0;
            pkt_pos[p] = 0;
            to_gen[p]  = 0;
            for (int v = 0; v < N_VC; v++) begin
                owner[p][v]     = -1;
                up_credit[p][v] = BUF_DEPTH;
                pend[p][v]      = 0;
                sent[p][v]      = 0;
                acked[p][v]     = 0;
                cur_route[p][v] = PORT_LOCAL;
                q_wr[p*N_VC+v]  = 0;
                q_rd[p*N_VC+v]  = 0;
            end
        end
        cyc         = 0;
        seq         = 0;
        rx_count    = 0;
        last_cyc    = 0;
        blocked_out = -1;
        ack_random  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "idle after reset";
        for (int i = 0; i < 10; i++) begin
            tick();
            check_count("ovalid bits", 0, int'(ovalid));
            for (int p = 0; p < N_PORTS; p++)
                check_count($sformatf("oack bits of port %0d", p), 0, int'(oack[p]));
        end

        test_name = "single flit";
        for (int i = 0; i < N_PORTS; i++) begin
            f  = make_flit(KIND_SINGLE, dir_x[i], dir_y[i], port_id_t'(i), seq);
            seq++;
            n0 = rx_count;
            send_flit(i, i % N_VC, f);
            t0 = cyc;
            n  = 0;
            while (rx_count == n0) begin
                tick();
                n++;
                if (n > 20)
                    fail_run("a single flit never left the router");
            end
            check_count("latency", 2, last_cyc - t0);
            check_port("direction", dir_p[i], last_port);
            check_flit("data", f, last_flit);
            check_count("vc", i % N_VC, int'(last_vc));
            repeat (4) tick();
        end

        test_name  = "random traffic";
        ack_random = 1'b1;
        run_traffic(30, -1, 0, 5000);

        test_name = "back-pressure";
        run_traffic(20, PORT_EAST, 300, 6000);

        test_name = "final counts";
        repeat (4) tick();
        for (int p = 0; p < N_PORTS; p++) begin
            for (int v = 0; v < N_VC; v++) begin
                check_count($sformatf("acks on port %0d vc %0d", p, v), sent[p][v], acked[p][v]);
                check_count("model queue depth", 0, q_wr[p*N_VC+v] - q_rd[p*N_VC+v]);
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/mesh_router.sv
`default_nettype none

module mesh_router #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  noc_pkg::coord_t             my_x,
    input  noc_pkg::coord_t             my_y,
    input  noc_pkg::flit_t              idata [noc_pkg::N_PORTS],
    input  logic [noc_pkg::N_PORTS-1:0] ivalid,
    input  noc_pkg::vc_id_t             ivch [noc_pkg::N_PORTS],
    output logic [noc_pkg::N_VC-1:0]    oack [noc_pkg::N_PORTS],
    output noc_pkg::flit_t              odata [noc_pkg::N_PORTS],
    output logic [noc_pkg::N_PORTS-1:0] ovalid,
    output noc_pkg::vc_id_t             ovch [noc_pkg::N_PORTS],
    input  logic [noc_pkg::N_VC-1:0]    iack [noc_pkg::N_PORTS]
);

    import noc_pkg::*;

    flit_t              head_flit  [N_PORTS][N_VC];
    logic [N_VC-1:0]    head_valid [N_PORTS];
    logic [N_VC-1:0]    pop        [N_PORTS];
    logic [N_VC-1:0]    credit_ok  [N_PORTS];
    logic [N_PORTS-1:0] sel_valid;
    port_id_t           sel_port   [N_PORTS];
    vc_id_t             sel_vc     [N_PORTS];

    for (genvar p = 0; p < N_PORTS; p++) begin : g_in
        vc_input_buffer #(
            .BUF_DEPTH(BUF_DEPTH)
        ) buf_i (
            .clk       (clk),
            .rst       (rst),
            .data      (idata[p]),
            .valid     (ivalid[p]),
            .vc        (ivch[p]),
            .pop       (pop[p]),
            .head_flit (head_flit[p]),
            .head_valid(head_valid[p]),
            .ack       (oack[p])
        );
    end

    switch_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .my_x      (my_x),
        .my_y      (my_y),
        .head_flit (head_flit),
        .head_valid(head_valid),
        .credit_ok (credit_ok),
        .pop       (pop),
        .sel_valid (sel_valid),
        .sel_port  (sel_port),
        .sel_vc    (sel_vc)
    );

    // every output sees all input heads and muxes by its own grant.
    for (genvar p = 0; p < N_PORTS; p++) begin : g_out
        output_unit #(
            .BUF_DEPTH(BUF_DEPTH)
        ) out_i (
            .clk      (clk),
            .rst      (rst),
            .in_flit  (head_flit),
            .sel_valid(sel_valid[p]),
            .sel_port (sel_port[p]),
            .sel_vc   (sel_vc[p]),
            .iack     (iack[p]),
            .odata    (odata[p]),
            .ovalid   (ovalid[p]),
            .ovch     (ovch[p]),
            .credit_ok(credit_ok[p])
        );
    end

endmodule

`default_nettype wire

// File: design/noc_pkg.sv
`default_nettype none

package noc_pkg;

    localparam int N_PORTS = 5;
    localparam int N_VC    = 2;

    localparam int FLIT_W    = 35;
    localparam int PAYLOAD_W = 29;
    localparam int DST_Y_LSB = PAYLOAD_W;       // fields are stacked above the payload.
    localparam int DST_X_LSB = DST_Y_LSB + 2;
    localparam int KIND_LSB  = DST_X_LSB + 2;

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [1:0]        flit_kind_t;
    typedef logic [1:0]        coord_t;
    typedef logic [2:0]        port_id_t;
    typedef logic [0:0]        vc_id_t;

    localparam port_id_t PORT_LOCAL = 3'd0;
    localparam port_id_t PORT_NORTH = 3'd1;
    localparam port_id_t PORT_EAST  = 3'd2;
    localparam port_id_t PORT_SOUTH = 3'd3;
    localparam port_id_t PORT_WEST  = 3'd4;

    localparam flit_kind_t KIND_BODY   = 2'd0;
    localparam flit_kind_t KIND_TAIL   = 2'd1;
    localparam flit_kind_t KIND_HEAD   = 2'd2;
    localparam flit_kind_t KIND_SINGLE = 2'd3;

    typedef enum logic {
        VC_FREE,
        VC_OWNED
    } vc_state_e;

    function automatic flit_kind_t flit_kind(flit_t f);
        return f[KIND_LSB +: 2];
    endfunction

    function automatic coord_t flit_dst_x(flit_t f);
        return f[DST_X_LSB +: 2];
    endfunction

    function automatic coord_t flit_dst_y(flit_t f);
        return f[DST_Y_LSB +: 2];
    endfunction

    // a head or single flit starts a packet and carries the destination.
    function automatic logic flit_opens(flit_t f);
        return (flit_kind(f) == KIND_HEAD) || (flit_kind(f) == KIND_SINGLE);
    endfunction

    function automatic logic flit_closes(flit_t f);
        return (flit_kind(f) == KIND_TAIL) || (flit_kind(f) == KIND_SINGLE);
    endfunction

endpackage

`default_nettype wire

// File: design/output_unit.sv
`default_nettype none

module output_unit #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  noc_pkg::flit_t           in_flit [noc_pkg::N_PORTS][noc_pkg::N_VC],
    input  logic                     sel_valid,
    input  noc_pkg::port_id_t        sel_port,
    input  noc_pkg::vc_id_t          sel_vc,
    input  logic [noc_pkg::N_VC-1:0] iack,
    output noc_pkg::flit_t           odata,
    output logic                     ovalid,
    output noc_pkg::vc_id_t          ovch,
    output logic [noc_pkg::N_VC-1:0] credit_ok
);

    import noc_pkg::*;

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    typedef logic [CNT_W-1:0] credit_t;

    credit_t credit [N_VC];
    flit_t   sel_flit;

    assign sel_flit = in_flit[sel_port][sel_vc];   // crossbar column for this output.

    always_ff @(posedge clk) begin
        odata <= sel_flit;
        ovch  <= sel_vc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ovalid <= 1'b0;
        end else begin
            ovalid <= sel_valid;
        end
    end

    for (genvar v = 0; v < N_VC; v++) begin : g_credit
        logic send;

        assign send = sel_valid && (sel_vc == vc_id_t'(v));

        always_ff @(posedge clk) begin
            if (rst) begin
                credit[v] <= credit_t'(BUF_DEPTH);   // downstream FIFO starts empty.
            end else begin
                case ({send, iack[v]})
                    2'b10:   credit[v] <= credit[v] - 1'b1;
                    2'b01:   credit[v] <= credit[v] + 1'b1;
                    default: credit[v] <= credit[v];
                endcase
            end
        end

        assign credit_ok[v] = (credit[v] != '0);
    end

endmodule

`default_nettype wire

// File: design/rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
    parameter int N_REQ = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [N_REQ-1:0] req,
    input  logic             advance,
    output logic [N_REQ-1:0] gnt
);

    localparam int PTR_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] gnt_idx;
    logic             found;

    always_comb begin
        int idx;
        gnt     = '0;
        gnt_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < N_REQ; i++) begin
            idx = (int'(ptr) + i) % N_REQ;     // scan starts at the pointer.
            if (!found && req[idx]) begin
                found    = 1'b1;
                gnt[idx] = 1'b1;
                gnt_idx  = PTR_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (advance && found) begin
            ptr <= (gnt_idx == PTR_W'(N_REQ - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/switch_ctrl.sv
`default_nettype none

module switch_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  noc_pkg::coord_t             my_x,
    input  noc_pkg::coord_t             my_y,
    input  noc_pkg::flit_t              head_flit [noc_pkg::N_PORTS][noc_pkg::N_VC],
    input  logic [noc_pkg::N_VC-1:0]    head_valid [noc_pkg::N_PORTS],
    input  logic [noc_pkg::N_VC-1:0]    credit_ok [noc_pkg::N_PORTS],
    output logic [noc_pkg::N_VC-1:0]    pop [noc_pkg::N_PORTS],
    output logic [noc_pkg::N_PORTS-1:0] sel_valid,
    output noc_pkg::port_id_t           sel_port [noc_pkg::N_PORTS],
    output noc_pkg::vc_id_t             sel_vc [noc_pkg::N_PORTS]
);

    import noc_pkg::*;

    port_id_t           route_q   [N_PORTS][N_VC];
    port_id_t           route_cur [N_PORTS][N_VC];
    vc_state_e          out_state [N_PORTS][N_VC];
    port_id_t           out_owner [N_PORTS][N_VC];
    logic [N_VC-1:0]    eligible  [N_PORTS];
    logic [N_VC-1:0]    vc_gnt    [N_PORTS];
    logic [N_PORTS-1:0] in_pick;
    vc_id_t             in_vc     [N_PORTS];
    port_id_t           in_route  [N_PORTS];
    logic [N_PORTS-1:0] out_req   [N_PORTS];
    logic [N_PORTS-1:0] out_gnt   [N_PORTS];
    logic [N_PORTS-1:0] in_won;
    flit_t              sel_flit  [N_PORTS];

    // dimension order, X is resolved before Y.
    function automatic port_id_t xy_route(flit_t f, coord_t x, coord_t y);
        port_id_t dir;
        if (flit_dst_x(f) > x)
            dir = PORT_EAST;
        else if (flit_dst_x(f) < x)
            dir = PORT_WEST;
        else if (flit_dst_y(f) > y)
            dir = PORT_NORTH;
        else if (flit_dst_y(f) < y)
            dir = PORT_SOUTH;
        else
            dir = PORT_LOCAL;
        return dir;
    endfunction

    always_comb begin
        port_id_t o;
        logic     own_ok;
        for (int i = 0; i < N_PORTS; i++) begin
            for (int v = 0; v < N_VC; v++) begin
                route_cur[i][v] = flit_opens(head_flit[i][v]) ?
                                  xy_route(head_flit[i][v], my_x, my_y) : route_q[i][v];
                o = route_cur[i][v];
                if (flit_opens(head_flit[i][v]))
                    own_ok = (out_state[o][v] == VC_FREE);
                else
                    own_ok = (out_state[o][v] == VC_OWNED) && (out_owner[o][v] == port_id_t'(i));
                eligible[i][v] = head_valid[i][v] && credit_ok[o][v] && own_ok;
            end
        end
    end

    for (genvar i = 0; i < N_PORTS; i++) begin : g_in
        rr_arbiter #(
            .N_REQ(N_VC)
        ) vc_arb_i (
            .clk    (clk),
            .rst    (rst),
            .req    (eligible[i]),
            .advance(in_won[i]),   // keep priority until the VC actually moves.
            .gnt    (vc_gnt[i])
        );
    end

    always_comb begin
        for (int i = 0; i < N_PORTS; i++) begin
            in_pick[i] = |vc_gnt[i];
            in_vc[i]   = '0;
            for (int v = 0; v < N_VC; v++) begin
                if (vc_gnt[i][v])
                    in_vc[i] = vc_id_t'(v);
            end
            in_route[i] = route_cur[i][in_vc[i]];
        end
        for (int o = 0; o < N_PORTS; o++) begin
            for (int i = 0; i < N_PORTS; i++) begin
                out_req[o][i] = in_pick[i] && (in_route[i] == port_id_t'(o));
            end
        end
    end

    for (genvar o = 0; o < N_PORTS; o++) begin : g_out
        rr_arbiter #(
            .N_REQ(N_PORTS)
        ) port_arb_i (
            .clk    (clk),
            .rst    (rst),
            .req    (out_req[o]),
            .advance(sel_valid[o]),
            .gnt    (out_gnt[o])
        );
    end

    always_comb begin
        in_won = '0;
        for (int o = 0; o < N_PORTS; o++) begin
            sel_valid[o] = |out_gnt[o];
            sel_port[o]  = '0;
            sel_vc[o]    = '0;
            sel_flit[o]  = head_flit[0][0];
            for (int i = 0; i < N_PORTS; i++) begin
                if (out_gnt[o][i]) begin
                    sel_port[o] = port_id_t'(i);
                    sel_vc[o]   = in_vc[i];
                    sel_flit[o] = head_flit[i][in_vc[i]];
                    in_won[i]   = 1'b1;
                end
            end
        end
        for (int i = 0; i < N_PORTS; i++) begin
            pop[i] = in_won[i] ? vc_gnt[i] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int o = 0; o < N_PORTS; o++) begin
                for (int v = 0; v < N_VC; v++) begin
                    out_state[o][v] <= VC_FREE;
                end
            end
        end else begin
            for (int o = 0; o < N_PORTS; o++) begin
                if (sel_valid[o] && flit_closes(sel_flit[o]))
                    out_state[o][sel_vc[o]] <= VC_FREE;   // single flits land here too.
                else if (sel_valid[o] && flit_opens(sel_flit[o]))
                    out_state[o][sel_vc[o]] <= VC_OWNED;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < N_PORTS; o++) begin
            if (sel_valid[o] && flit_opens(sel_flit[o]))
                out_owner[o][sel_vc[o]] <= sel_port[o];
        end
        for (int i = 0; i < N_PORTS; i++) begin
            for (int v = 0; v < N_VC; v++) begin
                if (pop[i][v] && flit_opens(head_flit[i][v]))
                    route_q[i][v] <= route_cur[i][v];   // body and tail follow the head.
            end
        end
    end

endmodule

`default_nettype wire

// File: design/vc_input_buffer.sv
`default_nettype none

module vc_input_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  noc_pkg::flit_t           data,
    input  logic                     valid,
    input  noc_pkg::vc_id_t          vc,
    input  logic [noc_pkg::N_VC-1:0] pop,
    output noc_pkg::flit_t           head_flit [noc_pkg::N_VC],
    output logic [noc_pkg::N_VC-1:0] head_valid,
    output logic [noc_pkg::N_VC-1:0] ack
);

    import noc_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    for (genvar v = 0; v < N_VC; v++) begin : g_vc
        flit_t mem [BUF_DEPTH];
        ptr_t  rd_ptr;
        ptr_t  wr_ptr;
        cnt_t  count;
        logic  push;

        assign push = valid && (vc == vc_id_t'(v));

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= data;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= next_ptr(wr_ptr);
                end
                if (pop[v]) begin
                    rd_ptr <= next_ptr(rd_ptr);
                end
                count <= count + cnt_t'(push) - cnt_t'(pop[v]);  // push and pop may overlap.
            end
        end

        assign head_flit[v]  = mem[rd_ptr];
        assign head_valid[v] = (count != '0);
    end

    // each freed slot is handed back upstream as one credit.
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= '0;
        end else begin
            ack <= pop;
        end
    end

endmodule

`default_nettype wire
